// ==== Makefile ====
# Verilator lint and simulation of the OSD overlay testbench
TOP = osdTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -o osdSim
	@out="$$(./obj_dir/osdSim)"; echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// ==== sources.f ====
src/osdPkg.sv
src/spiCmdReceiver.sv
src/osdBuffer.sv
src/syncAnalyzer.sv
src/osdWindow.sv
src/osdMixer.sv
src/osdTop.sv
tests/clockGen.sv
tests/osdTb.sv

// ==== src/osdBuffer.sv ====
// 8 rows of 256 bytes; contents are undefined until written over SPI
`timescale 1ns/1ns

module osdBuffer (
	input  logic SPI_SCK,
	input  osdPkg::bufWriteT bufWrite,
	input  logic [osdPkg::bufAddrW-1:0] rdAddr,
	output byte unsigned rdData
);

	// each byte is a column of 8 pixels, bit 0 on top
	logic [7:0] mem [0:(1 << osdPkg::bufAddrW) - 1];

	// write side runs on the SPI clock
	always_ff @(posedge SPI_SCK) begin
		if (bufWrite.we) begin
			mem[bufWrite.addr] <= bufWrite.data;
		end
	end

	// video side reads without a clock
	assign rdData = mem[rdAddr];

endmodule

// ==== src/osdMixer.sv ====
// one cycle from videoIn to videoOut both inside and outside the window
// the overlay background is always on
`timescale 1ns/1ns

module osdMixer (
	input  logic clk_sys,
	input  osdPkg::rgbT videoIn,
	input  logic osdDe,
	input  logic [2:0] pixSel,
	input  byte unsigned rdData,
	output osdPkg::rgbT videoOut
);

	logic pixBit;

	// pixel bit on top, colour pair below, dimmed video at the bottom
	function automatic logic [osdPkg::colorW-1:0] blend(
		input logic pix,
		input logic [1:0] colorPair,
		input logic [osdPkg::colorW-1:0] chan
	);
		return {{2{pix}}, colorPair, chan[osdPkg::colorW-1 -: 2]};
	endfunction

	// byte address is one pixel ahead, so the bit is held for a cycle
	always_ff @(posedge clk_sys) begin
		pixBit <= rdData[pixSel];
	end

	always_ff @(posedge clk_sys) begin
		if (osdDe) begin
			videoOut <= '{
				r: blend(pixBit, osdPkg::osdColor[5:4], videoIn.r),
				g: blend(pixBit, osdPkg::osdColor[3:2], videoIn.g),
				b: blend(pixBit, osdPkg::osdColor[1:0], videoIn.b)
			};
		end else begin
			videoOut <= videoIn;
		end
	end

endmodule

// ==== src/osdPkg.sv ====
// geometry and colour are fixed at build time
// sizes wrap at 10 bits so modes above 1023 pixels or lines are not measured
package osdPkg;

	// ********************************************************************
	// widths
	// ********************************************************************
	localparam int colorW = 6;
	localparam int cntW = 10;
	localparam int bufAddrW = 11;

	// ********************************************************************
	// window geometry and colour
	// ********************************************************************
	localparam logic [cntW-1:0] osdWidth = 10'd256;
	localparam logic [cntW-1:0] osdHeight = 10'd128;
	localparam logic [cntW-1:0] doubleScanLines = 10'd350;

	// shifts from the centred position
	localparam logic signed [cntW-1:0] osdXOffset = '0;
	localparam logic signed [cntW-1:0] osdYOffset = '0;

	// two bits each for r, g and b
	localparam logic [colorW-1:0] osdColor = '1;

	// command class from the top bits of the first byte
	typedef enum logic [1:0] {
		cmdNone,
		cmdWrite,
		cmdEnable
	} spiCmdE;

	typedef struct packed {
		logic [colorW-1:0] r;
		logic [colorW-1:0] g;
		logic [colorW-1:0] b;
	} rgbT;

	typedef struct packed {
		logic we;
		logic [bufAddrW-1:0] addr;
		logic [7:0] data;
	} bufWriteT;

	typedef struct packed {
		logic [cntW-1:0] hCnt;
		logic [cntW-1:0] vCnt;
		logic [cntW-1:0] dspWidth;
		logic [cntW-1:0] dspHeight;
		logic hActive;
		logic vActive;
	} videoTimingT;

endpackage

// ==== src/osdTop.sv ====
// every clk_sys cycle is one pixel; clk_sys should follow the core's pixel clock
// SPI_SCK is expected idle while the enable level crosses over
`timescale 1ns/1ns

module osdTop (
	input  logic clk_sys,
	input  logic SPI_SCK,
	input  logic SPI_SS3,
	input  logic SPI_DI,
	input  osdPkg::rgbT videoIn,
	input  logic hSync,
	input  logic vSync,
	output osdPkg::rgbT videoOut,
	output logic osdShown
);

	osdPkg::bufWriteT bufWrite;
	osdPkg::videoTimingT timing;
	logic osdEnable;
	logic [osdPkg::bufAddrW-1:0] rdAddr;
	byte unsigned rdData;
	logic osdDe;
	logic [2:0] pixSel;

	// enable level into the pixel clock
	always_ff @(posedge clk_sys) begin
		osdShown <= osdEnable;
	end

	spiCmdReceiver rx_i (
		.SPI_SCK(SPI_SCK),
		.SPI_SS3(SPI_SS3),
		.SPI_DI(SPI_DI),
		.bufWrite(bufWrite),
		.osdEnable(osdEnable)
	);

	osdBuffer buffer_i (
		.SPI_SCK(SPI_SCK),
		.bufWrite(bufWrite),
		.rdAddr(rdAddr),
		.rdData(rdData)
	);

	syncAnalyzer sync_i (
		.clk_sys(clk_sys),
		.hSync(hSync),
		.vSync(vSync),
		.timing(timing)
	);

	osdWindow window_i (
		.clk_sys(clk_sys),
		.timing(timing),
		.osdShown(osdShown),
		.rdAddr(rdAddr),
		.osdDe(osdDe),
		.pixSel(pixSel)
	);

	osdMixer mixer_i (
		.clk_sys(clk_sys),
		.videoIn(videoIn),
		.osdDe(osdDe),
		.pixSel(pixSel),
		.rdData(rdData),
		.videoOut(videoOut)
	);

endmodule

// ==== src/osdWindow.sv ====
// window is centred on the measured display; height doubles above 350 lines
// the byte address runs two pixels ahead of the beam
`timescale 1ns/1ns

module osdWindow (
	input  logic clk_sys,
	input  osdPkg::videoTimingT timing,
	input  logic osdShown,
	output logic [osdPkg::bufAddrW-1:0] rdAddr,
	output logic osdDe,
	output logic [2:0] pixSel
);

	logic doubleScan;
	logic [osdPkg::cntW-1:0] winHeight;
	logic [osdPkg::cntW-1:0] hSpare;
	logic [osdPkg::cntW-1:0] vSpare;
	logic [osdPkg::cntW-1:0] hStart;
	logic [osdPkg::cntW-1:0] hEnd;
	logic [osdPkg::cntW-1:0] vStart;
	logic [osdPkg::cntW-1:0] vEnd;
	logic [osdPkg::cntW-1:0] osdH;
	logic [osdPkg::cntW-1:0] osdV;
	logic [osdPkg::cntW-1:0] osdHNext2;
	logic [2:0] rowSel;
	logic inWindow;

	// ********************************************************************
	// window placement
	// ********************************************************************
	assign doubleScan = timing.dspHeight > osdPkg::doubleScanLines;
	assign winHeight = doubleScan ? (osdPkg::osdHeight << 1) : osdPkg::osdHeight;

	assign hSpare = timing.dspWidth - osdPkg::osdWidth;
	assign vSpare = timing.dspHeight - winHeight;

	assign hStart = (hSpare >> 1) + osdPkg::osdXOffset;
	assign hEnd = hStart + osdPkg::osdWidth;
	assign vStart = (vSpare >> 1) + osdPkg::osdYOffset;
	assign vEnd = vStart + winHeight;

	assign inWindow = (timing.hCnt >= hStart) && (timing.hCnt < hEnd) &&
		(timing.vCnt >= vStart) && (timing.vCnt < vEnd);

	assign osdDe = osdShown && timing.hActive && timing.vActive && inWindow;

	// ********************************************************************
	// buffer addressing
	// ********************************************************************

	// beam position relative to the window corner
	assign osdH = timing.hCnt - hStart;
	assign osdV = timing.vCnt - vStart;
	assign osdHNext2 = osdH + 2'd2;

	// 16 lines per buffer row, 32 in double scan
	assign rowSel = doubleScan ? osdV[7:5] : osdV[6:4];

	always_ff @(posedge clk_sys) begin
		rdAddr <= {rowSel, osdHNext2[7:0]};
		pixSel <= doubleScan ? osdV[4:2] : osdV[3:1];
	end

endmodule

// ==== src/spiCmdReceiver.sv ====
// SPI mode 0 with MSB first; SPI_SS3 high frames every transfer
// the enable level survives between transfers and powers up at 0
`timescale 1ns/1ns

module spiCmdReceiver (
	input  logic SPI_SCK,
	input  logic SPI_SS3,
	input  logic SPI_DI,
	output osdPkg::bufWriteT bufWrite,
	output logic osdEnable
);

	logic [4:0] bitCnt;
	logic [7:0] shiftReg;
	logic [7:0] rxByte;
	logic [osdPkg::bufAddrW-1:0] wrAddr;
	logic writeStrobe;
	osdPkg::spiCmdE cmd;
	osdPkg::spiCmdE rxCmd;
	logic enableReg = 1'b0;

	// byte completed by the bit on the line now
	assign rxByte = {shiftReg[6:0], SPI_DI};

	always_comb begin
		if (rxByte[7:3] == 5'b00100) begin
			rxCmd = osdPkg::cmdWrite;
		end else if (rxByte[7:4] == 4'b0100) begin
			rxCmd = osdPkg::cmdEnable;
		end else begin
			rxCmd = osdPkg::cmdNone;
		end
	end

	// ********************************************************************
	// bit and byte framing
	// ********************************************************************

	// counts 0..7 cover the command byte, then 8..15 repeat per data byte
	always_ff @(posedge SPI_SCK or posedge SPI_SS3) begin
		if (SPI_SS3) begin
			bitCnt <= '0;
			wrAddr <= '0;
		end else begin
			if (bitCnt < 5'd15) begin
				bitCnt <= bitCnt + 5'd1;
			end else begin
				bitCnt <= 5'd8;
			end

			// low command bits pick the row, column restarts at 0
			if (bitCnt == 5'd7) begin
				wrAddr <= {rxByte[2:0], 8'h00};
			end else if (writeStrobe) begin
				wrAddr <= wrAddr + 1'b1;
			end
		end
	end

	// ********************************************************************
	// command latch and enable register
	// ********************************************************************
	always_ff @(posedge SPI_SCK) begin
		shiftReg <= rxByte;
		if (bitCnt == 5'd7) begin
			cmd <= rxCmd;
			if (rxCmd == osdPkg::cmdEnable) begin
				enableReg <= SPI_DI;
			end
		end
	end

	// strobe lasts while the last bit of a data byte is on the line
	assign writeStrobe = (cmd == osdPkg::cmdWrite) && (bitCnt == 5'd15);

	assign bufWrite = '{we: writeStrobe, addr: wrAddr, data: rxByte};
	assign osdEnable = enableReg;

endmodule

// ==== src/syncAnalyzer.sv ====
// one clk_sys cycle per pixel; sizes are valid after one full frame of sync
// the longer phase of each sync is taken as the display
`timescale 1ns/1ns

module syncAnalyzer (
	input  logic clk_sys,
	input  logic hSync,
	input  logic vSync,
	output osdPkg::videoTimingT timing
);

	logic hsD;
	logic hsD2;
	logic vsD;
	logic vsD2;
	logic hsFall;
	logic hsRise;
	logic vsFall;
	logic vsRise;
	logic [osdPkg::cntW-1:0] hCnt;
	logic [osdPkg::cntW-1:0] vCnt;
	logic [osdPkg::cntW-1:0] hsLow;
	logic [osdPkg::cntW-1:0] hsHigh;
	logic [osdPkg::cntW-1:0] vsLow;
	logic [osdPkg::cntW-1:0] vsHigh;
	logic hsPol;
	logic vsPol;

	// ********************************************************************
	// sync sampling and edges
	// ********************************************************************
	always_ff @(posedge clk_sys) begin
		hsD <= hSync;
		hsD2 <= hsD;
		vsD <= vSync;
		vsD2 <= vsD;
	end

	assign hsFall = hsD2 && !hsD;
	assign hsRise = !hsD2 && hsD;
	assign vsFall = vsD2 && !vsD;
	assign vsRise = !vsD2 && vsD;

	// ********************************************************************
	// beam counters and phase lengths
	// ********************************************************************
	always_ff @(posedge clk_sys) begin
		if (hsFall) begin
			hCnt <= '0;
			hsHigh <= hCnt;
		end else if (hsRise) begin
			hCnt <= '0;
			hsLow <= hCnt;
		end else begin
			hCnt <= hCnt + 1'b1;
		end
	end

	// a vsync edge wins over the line step
	always_ff @(posedge clk_sys) begin
		if (vsFall) begin
			vCnt <= '0;
			vsHigh <= vCnt;
		end else if (vsRise) begin
			vCnt <= '0;
			vsLow <= vCnt;
		end else if (hsRise) begin
			vCnt <= vCnt + 1'b1;
		end
	end

	// the sync pulse is the shorter phase
	assign hsPol = hsHigh < hsLow;
	assign vsPol = vsHigh < vsLow;

	assign timing = '{
		hCnt: hCnt,
		vCnt: vCnt,
		dspWidth: hsPol ? hsLow : hsHigh,
		dspHeight: vsPol ? vsLow : vsHigh,
		hActive: hsD2 != hsPol,
		vActive: vsD2 != vsPol
	};

endmodule

// ==== tests/clockGen.sv ====
// free-running pixel clock with an 8 ns period
// reset is high until 1 ns after the 4th rising edge
`timescale 1ns/1ns

module clockGen (
	output logic clk_sys,
	output logic rst
);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#4;
			clk_sys = ~clk_sys;
		end
	end

	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk_sys);
		#1;
		rst = 1'b0;
	end

endmodule

// ==== tests/osdTb.sv ====
// lines are 320 active pixels plus a 16 pixel low hSync, frames end in 4 low vSync lines
// SPI transfers only run while the video generator is idle
`timescale 1ns/1ns

module osdTb;

	localparam int lineLen = 336;
	localparam int activePix = 320;
	localparam longint shortFrame = 164 * lineLen;
	localparam longint tallFrame = 364 * lineLen;
	localparam longint xferLen = (8 + 256 * 8) * 4 + 16;
	// 12 short frames, 2 tall frames and 28 transfers plus margin
	localparam longint runCycles = 12 * shortFrame + 2 * tallFrame + 30 * xferLen + 20000;

	logic clk_sys;
	logic rstHold;
	logic ssLine = 1'b1;
	logic SPI_SCK = 1'b0;
	logic SPI_DI = 1'b0;
	logic hSync = 1'b0;
	logic vSync = 1'b0;
	osdPkg::rgbT videoIn = '0;
	osdPkg::rgbT prevIn = '0;
	osdPkg::rgbT videoOut;
	logic osdShown;
	logic [31:0] lfsrState = 32'h8515_62bd;
	string testName = "reset";

	clockGen clkGen_i (.clk_sys(clk_sys), .rst(rstHold));

	osdTop dut_i (
		.clk_sys(clk_sys),
		.SPI_SCK(SPI_SCK),
		.SPI_SS3(rstHold | ssLine),
		.SPI_DI(SPI_DI),
		.videoIn(videoIn),
		.hSync(hSync),
		.vSync(vSync),
		.videoOut(videoOut),
		.osdShown(osdShown)
	);

	// ********************************************************************
	// random source and checks
	// ********************************************************************
	function automatic logic [31:0] randomBits(input int nBits);
		logic [31:0] value;
		logic outBit;
		int i;
		value = '0;
		for (i = 0; i < nBits; i++) begin
			outBit = lfsrState[0];
			lfsrState = lfsrState >> 1;
			if (outBit) begin
				lfsrState = lfsrState ^ 32'h8020_0003;
			end
			value = {value[30:0], outBit};
		end
		return value;
	endfunction

	// r bits 3:2 stay clear so plain video never carries the overlay colour
	function automatic osdPkg::rgbT randomPixel();
		osdPkg::rgbT pix;
		pix.r = 6'(randomBits(6));
		pix.g = 6'(randomBits(6));
		pix.b = 6'(randomBits(6));
		pix.r[3:2] = 2'b00;
		return pix;
	endfunction

	task automatic checkEq(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("MISMATCH %s %s: expected %0h, actual %0h", testName, what, expected,
				actual);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	// ********************************************************************
	// SPI driver, mode 0 at a quarter of clk_sys
	// ********************************************************************
	task automatic spiByte(input logic [7:0] value);
		int i;
		for (i = 7; i >= 0; i--) begin
			@(posedge clk_sys);
			#1;
			SPI_SCK = 1'b0;
			SPI_DI = value[i];
			repeat (2) @(posedge clk_sys);
			#1;
			SPI_SCK = 1'b1;
			@(posedge clk_sys);
		end
	endtask

	task automatic spiSelect(input logic level);
		@(posedge clk_sys);
		#1;
		SPI_SCK = 1'b0;
		ssLine = level;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic writeRow(input int row, input bit useRandom, input logic [7:0] fill);
		int col;
		spiSelect(1'b0);
		spiByte(8'h20 | 8'(row));
		for (col = 0; col < 256; col++) begin
			spiByte(useRandom ? 8'(randomBits(8)) : fill);
		end
		spiSelect(1'b1);
	endtask

	task automatic setEnable(input logic level);
		int n;
		spiSelect(1'b0);
		spiByte({7'b0100_000, level});
		spiSelect(1'b1);
		n = 0;
		while (osdShown !== level && n < 8) begin
			@(posedge clk_sys);
			#1;
			n++;
		end
		checkEq("osdShown", 32'(level), 32'(osdShown));
	endtask

	// ********************************************************************
	// video generator and output checker
	// ********************************************************************

	// mode 0 passthrough only, 1 any overlay, 2 all set, 3 only row 0 set
	task automatic runFrame(input int lines, input int mode, output int ovLines);
		int line;
		int pix;
		int ovCount;
		int ones;
		int first;
		int last;
		logic pixBit;
		osdPkg::rgbT out;
		osdPkg::rgbT blended;
		ovLines = 0;
		for (line = 0; line < lines + 4; line++) begin
			ovCount = 0;
			ones = 0;
			first = 0;
			last = 0;
			for (pix = 0; pix < lineLen; pix++) begin
				@(posedge clk_sys);
				#1;
				out = videoOut;
				if (mode != 0 && out.r[3:2] == 2'b11 && out.g[3:2] == 2'b11 &&
					out.b[3:2] == 2'b11) begin
					pixBit = out.r[5];
					blended.r = {{2{pixBit}}, 2'b11, prevIn.r[5:4]};
					blended.g = {{2{pixBit}}, 2'b11, prevIn.g[5:4]};
					blended.b = {{2{pixBit}}, 2'b11, prevIn.b[5:4]};
					checkEq("blended pixel", 32'(blended), 32'(out));
					if (ovCount == 0) begin
						first = pix;
					end
					last = pix;
					ovCount++;
					ones += int'(pixBit);
				end else begin
					checkEq("passthrough pixel", 32'(prevIn), 32'(out));
				end
				hSync = pix < activePix;
				vSync = line < lines;
				videoIn = randomPixel();
				prevIn = videoIn;
			end
			if (ovCount > 0) begin
				ovLines++;
				if (mode >= 2) begin
					checkEq("overlay width", 256, 32'(ovCount));
					checkEq("overlay run length", 32'(ovCount), 32'(last - first + 1));
					checkEq("set pixel bits", (mode == 3 && ovLines > 16) ? 0 : 32'(ovCount),
						32'(ones));
				end
			end
		end
	endtask

	// ********************************************************************
	// directed tests
	// ********************************************************************
	task automatic testPassthrough();
		int ovLines;
		testName = "passthrough";
		checkEq("osdShown", 0, 32'(osdShown));
		runFrame(160, 0, ovLines);
		runFrame(160, 0, ovLines);
	endtask

	task automatic testEnable();
		int ovLines;
		int row;
		testName = "enable";
		for (row = 0; row < 8; row++) begin
			writeRow(row, 1'b1, 8'h00);
		end
		setEnable(1'b1);
		runFrame(160, 1, ovLines);
		runFrame(160, 1, ovLines);
		checkEq("overlay lines", 128, 32'(ovLines));
		setEnable(1'b0);
		runFrame(160, 0, ovLines);
		runFrame(160, 0, ovLines);
	endtask

	task automatic testWindow();
		int ovLines;
		int row;
		testName = "window";
		for (row = 0; row < 8; row++) begin
			writeRow(row, 1'b0, 8'hff);
		end
		setEnable(1'b1);
		runFrame(160, 2, ovLines);
		runFrame(160, 2, ovLines);
		checkEq("overlay lines", 128, 32'(ovLines));
	endtask

	task automatic testDoubleScan();
		int ovLines;
		testName = "double scan";
		runFrame(360, 2, ovLines);
		runFrame(360, 2, ovLines);
		checkEq("overlay lines", 256, 32'(ovLines));
	endtask

	task automatic testContent();
		int ovLines;
		int row;
		testName = "content";
		writeRow(0, 1'b0, 8'hff);
		for (row = 1; row < 8; row++) begin
			writeRow(row, 1'b0, 8'h00);
		end
		// first frame still runs with the height measured on the tall frames
		runFrame(160, 1, ovLines);
		runFrame(160, 3, ovLines);
		checkEq("overlay lines", 128, 32'(ovLines));
	endtask

	// data bytes that look like commands must be ignored too
	task automatic testIgnored();
		int ovLines;
		int n;
		testName = "ignored command";
		spiSelect(1'b0);
		spiByte(8'h10);
		spiByte(8'h40);
		spiByte(8'h20);
		for (n = 0; n < 14; n++) begin
			spiByte(8'(randomBits(8)));
		end
		spiSelect(1'b1);
		checkEq("osdShown", 1, 32'(osdShown));
		runFrame(160, 3, ovLines);
		runFrame(160, 3, ovLines);
		checkEq("overlay lines", 128, 32'(ovLines));
	endtask

	initial begin
		@(negedge rstHold);
		@(posedge clk_sys);
		#1;
		testPassthrough();
		testEnable();
		testWindow();
		testDoubleScan();
		testContent();
		testIgnored();
		$display("ALL CHECKS PASSED");
		$finish;
	end

	initial begin
		#(runCycles * 8);
		$display("watchdog expired before the tests finished");
		$display("CHECKS FAILED");
		$fatal(1);
	end

endmodule
